/* compile.f */
cpu_pkg.sv
block_ram.sv
host_port.sv
page_mmu.sv
reg_alu.sv
instr_sequencer.sv
cpu_top.sv
tb_clock.sv
tb_top.sv

/* Makefile */
TOP := tb_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb_top.sv */
`timescale 1ns/1ps

module tb_top import cpu_pkg::*; ();

  localparam int clk_period   = 10;
  localparam int mem_words    = page_count * page_words;
  localparam int acc_max      = 8;                   // cycles for one host access
  localparam int xlat_max     = 2 * page_count + 4;  // walk, scan and handshake
  localparam int instr_max    = 3 * xlat_max + 12;   // fetch, operand and data translate
  localparam int prog_instrs  = 40;                  // longest program
  localparam int accesses     = 4 * mem_words;       // fill, programs, two readbacks
  localparam int limit_cycles = accesses * acc_max + 2 * prog_instrs * instr_max + 100;

  logic                  clka;
  logic                  rst;
  logic                  restart;
  logic                  run;
  logic                  host_req;
  logic                  host_we;
  logic [addr_w-1:0]     host_addr;
  logic [data_w-1:0]     host_wdata;
  logic                  host_ack;
  logic [data_w-1:0]     host_rdata;
  logic                  halted;
  logic                  fault;

  logic [data_w-1:0]     exp_mem [mem_words];  // reference memory image
  logic [data_w-1:0]     prog [$];             // program words from physical 0
  logic                  map_ok [page_count];  // model page table indexed by logical page
  logic [page_idx_w-1:0] map_pg [page_count];
  int                    next_free;            // first-touch allocation
  logic                  model_fault;
  logic [31:0]           rng;

  tb_clock u_clk (.restart(restart), .clka(clka), .rst(rst));

  cpu_top u_dut (
    .clka(clka), .rst(rst), .run(run),
    .host_req(host_req), .host_we(host_we), .host_addr(host_addr), .host_wdata(host_wdata),
    .host_ack(host_ack), .host_rdata(host_rdata), .halted(halted), .fault(fault)
  );

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic expect_word(input logic [data_w-1:0] got, input logic [data_w-1:0] want,
                             input string what);
    assert (got === want)
      else abort_run($sformatf("mismatch at %0t ns: %s is %h, expected %h",
                               $time, what, got, want));
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [data_w-1:0] rand16();
    rng = xorshift(rng);
    return rng[15:0];
  endfunction

  // odd multiplier keeps every address distinct
  function automatic logic [data_w-1:0] fill_word(input logic [addr_w-1:0] a);
    return (16'(a) * 16'h9e37) ^ 16'h5a5a;
  endfunction

  function automatic void reset_model();
    foreach (map_ok[i]) map_ok[i] = 1'b0;
    map_ok[0]   = 1'b1;  // logical 0 sits in physical 0
    map_pg[0]   = '0;
    next_free   = 1;
    model_fault = 1'b0;
  endfunction

  function automatic logic [addr_w-1:0] phys_of(input logic [addr_w-1:0] la);
    logic [page_idx_w-1:0] lp;
    lp = la[addr_w-1:page_bits];
    if (!map_ok[lp]) begin
      if (next_free == page_count) begin
        model_fault = 1'b1;  // nothing left to hand out
        return '0;
      end
      map_ok[lp] = 1'b1;
      map_pg[lp] = page_idx_w'(next_free);
      next_free++;
    end
    return {map_pg[lp], la[page_bits-1:0]};
  endfunction

  // runs the loaded program on exp_mem
  task automatic run_model();
    logic [addr_w-1:0]    pc;
    logic [addr_w-1:0]    pa;
    logic [data_w-1:0]    hd;
    logic [data_w-1:0]    arg;
    logic [reg_idx_w-1:0] ri;
    logic [data_w-1:0]    r [reg_count];
    logic                 done;
    int                   steps;
    pc    = '0;
    done  = 1'b0;
    steps = 0;
    foreach (r[i]) r[i] = '0;
    while (!done && !model_fault && steps < prog_instrs) begin
      hd    = exp_mem[phys_of(pc)];
      arg   = exp_mem[phys_of(pc + 10'd1)];
      ri    = hd[reg_idx_w-1:0];  // low bits of the register byte
      pc    = pc + 10'd2;
      steps++;
      case (hd[15:8])
        op_jmp:       pc = arg[addr_w-1:0];
        op_num2reg:   r[ri] = arg;
        op_reg_plus:  r[ri] = r[ri] + arg;  // wraps at 16 bits
        op_reg_minus: r[ri] = r[ri] - arg;
        op_reg2ram: begin
          pa = phys_of(arg[addr_w-1:0]);
          if (!model_fault) exp_mem[pa] = r[ri];
        end
        op_ram2reg: begin
          pa = phys_of(arg[addr_w-1:0]);
          if (!model_fault) r[ri] = exp_mem[pa];
        end
        op_exit:      done = 1'b1;
        default:      ;  // skipped
      endcase
    end
  endtask

  // one four-phase host access from falling edge to falling edge
  task automatic host_access(input logic we, input logic [addr_w-1:0] addr,
                             input logic [data_w-1:0] wdata, output logic [data_w-1:0] rdata);
    int waited;
    int want;
    want = we ? 1 : 2;  // ack delay while the core is idle
    expect_word(16'(host_ack), 16'd0, "host_ack before request");
    @(posedge clka);
    host_we    <= we;
    host_addr  <= addr;
    host_wdata <= wdata;
    host_req   <= 1'b1;
    waited = 0;
    @(negedge clka);
    while (!host_ack) begin
      waited++;
      if (waited > acc_max) abort_run("host_ack never rose for a host access");
      @(negedge clka);
    end
    rdata = host_rdata;
    assert (waited == want)
      else abort_run($sformatf("mismatch at %0t ns: host_ack after %0d cycles, expected %0d",
                               $time, waited, want));
    @(posedge clka);
    host_req <= 1'b0;
    @(negedge clka);
    expect_word(16'(host_ack), 16'd1, "host_ack while req still seen high");
    @(negedge clka);
    expect_word(16'(host_ack), 16'd0, "host_ack after req fell");
  endtask

  task automatic emit(input logic [7:0] op, input logic [reg_idx_w-1:0] idx,
                      input logic [data_w-1:0] arg);
    prog.push_back({op, 5'b00101, idx});  // junk upper bits in the register byte
    prog.push_back(arg);
  endtask

  task automatic load_program();
    logic [data_w-1:0] d;
    foreach (prog[i]) begin
      host_access(1'b1, addr_w'(i), prog[i], d);
      exp_mem[i] = prog[i];
    end
  endtask

  task automatic run_program();
    int waited;
    @(posedge clka);
    run <= 1'b1;
    waited = 0;
    @(negedge clka);
    while (!halted) begin
      waited++;
      if (waited > prog_instrs * instr_max) abort_run("core did not halt in time");
      @(negedge clka);
    end
    expect_word(16'(fault), 16'(model_fault), "fault after halt");
  endtask

  task automatic check_memory();
    logic [data_w-1:0] d;
    for (int i = 0; i < mem_words; i++) begin
      host_access(1'b0, addr_w'(i), '0, d);
      expect_word(d, exp_mem[i], $sformatf("ram[%03h]", i));
    end
  endtask

  task automatic check_reset_state();
    expect_word(16'(host_ack), 16'd0, "host_ack after reset");
    expect_word(16'(halted), 16'd0, "halted after reset");
    expect_word(16'(fault), 16'd0, "fault after reset");
  endtask

  // fault only ever shows up with halted
  always @(negedge clka) begin
    if (rst) begin
      assert (!fault || halted)
        else abort_run($sformatf("mismatch at %0t ns: fault high while halted low", $time));
    end
  end

  initial begin
    #(limit_cycles * clk_period);
    $display("timeout, the run did not finish within %0d cycles", limit_cycles);
    $display("ERRORS FOUND");
    $fatal(1);
  end

  initial begin
    logic [data_w-1:0] d;
    logic [data_w-1:0] r;
    restart    = 1'b0;
    run        = 1'b0;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    rng        = 32'h9985;
    @(posedge rst);  // released after two reset cycles
    @(negedge clka);
    check_reset_state();

    for (int i = 0; i < mem_words; i++) begin  // fill every word
      host_access(1'b1, addr_w'(i), fill_word(addr_w'(i)), d);
      exp_mem[i] = fill_word(addr_w'(i));
    end
    for (int i = 0; i < 16; i++) begin  // host round trip on random words
      r = rand16();
      host_access(1'b0, r[addr_w-1:0], '0, d);
      expect_word(d, fill_word(r[addr_w-1:0]), "host readback of fill");
    end

    prog.delete();
    emit(op_num2reg,   3'd1, rand16());
    emit(op_reg_plus,  3'd1, rand16());
    emit(op_num2reg,   3'd2, rand16());
    emit(op_reg_minus, 3'd2, rand16());
    emit(op_reg2ram,   3'd1, 16'h0030);  // page 0 past the end of the program
    emit(op_reg2ram,   3'd2, 16'h0031);
    emit(op_num2reg,   3'd3, rand16());
    emit(op_reg2ram,   3'd3, 16'h00c5);  // logical page 3 takes the first new page
    emit(op_reg2ram,   3'd3, 16'h028a);  // logical page 10
    emit(op_reg2ram,   3'd1, 16'h00d0);  // page 3 again
    emit(op_ram2reg,   3'd4, 16'h01f7);  // logical page 7 still holds its fill
    emit(op_reg2ram,   3'd4, 16'h0032);
    emit(op_jmp,       3'd0, 16'(prog.size() + 4));  // skips the next instruction
    emit(op_num2reg,   3'd1, rand16());              // must have no effect
    emit(op_reg2ram,   3'd1, 16'h0033);
    emit(op_exit,      3'd0, 16'h0000);
    load_program();
    reset_model();
    run_model();
    run_program();
    expect_word(16'(fault), 16'd0, "fault after exit");
    check_memory();

    @(posedge clka);  // second reset keeps the memory contents
    run     <= 1'b0;
    restart <= 1'b1;
    @(posedge clka);
    restart <= 1'b0;
    repeat (3) @(negedge clka);
    check_reset_state();

    prog.delete();
    emit(op_num2reg, 3'd5, rand16());
    for (int k = 1; k < page_count; k++) begin  // all logical pages in scrambled order
      r = rand16();
      emit(op_reg_plus, 3'd5, r);
      emit(op_reg2ram, 3'd5, {6'd0, 4'((k * 7) % page_count), r[page_bits-1:0]});
    end
    emit(op_exit, 3'd0, 16'h0000);
    load_program();
    reset_model();
    run_model();
    run_program();
    check_memory();

    $display("NO ERRORS");
    $finish;
  end

endmodule

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
  input  logic restart,  // pulse for a second reset
  output logic clka,
  output logic rst
);

  logic [1:0] hold;  // reset cycles still to go

  initial begin
    clka = 1'b0;
    rst  = 1'b0;  // low from time zero
    hold = 2'd2;
  end

  always #5 clka = ~clka;  // 10 ns period

  always @(posedge clka) begin
    if (restart) begin
      hold <= 2'd2;
      rst  <= 1'b0;
    end else if (hold != 2'd0) begin
      hold <= hold - 2'd1;
      rst  <= (hold == 2'd1);  // released after the second edge
    end
  end

endmodule

/* cpu_top.sv */
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
  input  logic              clka,
  input  logic              rst,
  input  logic              run,
  input  logic              host_req,
  input  logic              host_we,
  input  logic [addr_w-1:0] host_addr,
  input  logic [data_w-1:0] host_wdata,
  output logic              host_ack,
  output logic [data_w-1:0] host_rdata,
  output logic              halted,
  output logic              fault
);

  logic                 xlat_req;   // sequencer -> mmu
  logic [addr_w-1:0]    xlat_addr;  // logical address
  logic                 xlat_ack;
  xlat_rsp_t            xlat_rsp;
  ram_wr_t              core_wr;    // physical traffic from the core
  ram_rd_t              core_rd;
  ram_wr_t              ram_wr;     // after the host/core mux
  ram_rd_t              ram_rd;
  mem_word_u            ram_rdata;
  reg_op_t              reg_op;
  logic [reg_idx_w-1:0] reg_sel;
  logic [data_w-1:0]    reg_value;
  logic                 core_idle;

  host_port u_host (
    .clka(clka), .rst(rst),
    .host_req(host_req), .host_we(host_we), .host_addr(host_addr), .host_wdata(host_wdata),
    .host_ack(host_ack), .host_rdata(host_rdata),
    .core_idle(core_idle), .core_wr(core_wr), .core_rd(core_rd),
    .ram_wr(ram_wr), .ram_rd(ram_rd), .ram_rdata(ram_rdata)
  );

  instr_sequencer u_seq (
    .clka(clka), .rst(rst), .run(run),
    .xlat_req(xlat_req), .xlat_addr(xlat_addr), .xlat_ack(xlat_ack), .xlat_rsp(xlat_rsp),
    .ram_wr(core_wr), .ram_rd(core_rd), .ram_rdata(ram_rdata),
    .reg_op(reg_op), .reg_sel(reg_sel), .reg_value(reg_value),
    .core_idle(core_idle), .halted(halted), .fault(fault)
  );

  reg_alu u_regs (
    .clka(clka), .rst(rst), .reg_op(reg_op), .reg_sel(reg_sel), .reg_value(reg_value)
  );

  page_mmu u_mmu (
    .clka(clka), .rst(rst),
    .xlat_req(xlat_req), .xlat_addr(xlat_addr), .xlat_ack(xlat_ack), .xlat_rsp(xlat_rsp)
  );

  block_ram u_ram (
    .clka(clka), .wr(ram_wr), .rd(ram_rd), .rdata(ram_rdata)
  );

endmodule

/* instr_sequencer.sv */
`timescale 1ns/1ps

module instr_sequencer import cpu_pkg::*; (
  input  logic                 clka,
  input  logic                 rst,
  input  logic                 run,
  output logic                 xlat_req,
  output logic [addr_w-1:0]    xlat_addr,
  input  logic                 xlat_ack,
  input  xlat_rsp_t            xlat_rsp,
  output ram_wr_t              ram_wr,
  output ram_rd_t              ram_rd,
  input  mem_word_u            ram_rdata,
  output reg_op_t              reg_op,
  output logic [reg_idx_w-1:0] reg_sel,
  input  logic [data_w-1:0]    reg_value,
  output logic                 core_idle,
  output logic                 halted,
  output logic                 fault
);

  logic [3:0]        state;
  logic [3:0]        ret_st;   // state after the translate
  logic [addr_w-1:0] pc;
  logic [addr_w-1:0] phys;     // last translated address
  mem_word_u         head_q;   // opcode and register byte
  logic [data_w-1:0] operand;  // second instruction word

  assign halted    = (state == sq_halt);
  assign core_idle = (state == sq_stop) || halted;
  assign reg_sel   = head_q.head.reg_sel[reg_idx_w-1:0];  // low bits pick the register

  always_comb begin
    ram_rd.en    = (state == sq_rd_head) || (state == sq_rd_arg) || (state == sq_rd_data);
    ram_rd.addr  = phys;
    ram_wr.en    = (state == sq_wr_data);
    ram_wr.addr  = phys;
    ram_wr.data  = reg_value;  // reg2ram source
    reg_op.kind  = kind_none;
    reg_op.idx   = reg_sel;
    reg_op.value = operand;
    if (state == sq_get_data) begin
      reg_op.kind  = kind_load;  // ram2reg result
      reg_op.value = ram_rdata.raw;
    end else if (state == sq_exec) begin
      case (head_q.head.op)
        op_num2reg:   reg_op.kind = kind_load;
        op_reg_plus:  reg_op.kind = kind_add;
        op_reg_minus: reg_op.kind = kind_sub;
        default:      reg_op.kind = kind_none;
      endcase
    end
  end

  always_ff @(posedge clka) begin
    if (!rst) begin
      state    <= sq_stop;
      pc       <= '0;
      xlat_req <= 1'b0;
      fault    <= 1'b0;
    end else begin
      case (state)
        sq_stop:  if (run) state <= sq_fetch;
        sq_fetch: begin
          xlat_addr <= pc;
          ret_st    <= sq_rd_head;
          state     <= sq_xlat;
        end
        sq_xlat: begin
          if (!xlat_req && !xlat_ack) begin
            xlat_req <= 1'b1;  // previous handshake fully closed
          end else if (xlat_req && xlat_ack) begin
            xlat_req <= 1'b0;
            phys     <= xlat_rsp.phys_addr;
            if (xlat_rsp.fault) begin
              fault <= 1'b1;  // halts with fault in the same cycle
              state <= sq_halt;
            end else begin
              state <= ret_st;
            end
          end
        end
        sq_rd_head: state <= sq_get_head;
        sq_get_head: begin
          head_q    <= ram_rdata;
          pc        <= pc + 1'b1;
          xlat_addr <= pc + 1'b1;  // operand word
          ret_st    <= sq_rd_arg;
          state     <= sq_xlat;
        end
        sq_rd_arg: state <= sq_get_arg;
        sq_get_arg: begin
          operand <= ram_rdata.raw;
          pc      <= pc + 1'b1;
          state   <= sq_exec;
        end
        sq_exec: begin
          case (head_q.head.op)
            op_jmp: begin
              pc    <= operand[addr_w-1:0];
              state <= sq_fetch;
            end
            op_reg2ram: begin
              xlat_addr <= operand[addr_w-1:0];
              ret_st    <= sq_wr_data;
              state     <= sq_xlat;
            end
            op_ram2reg: begin
              xlat_addr <= operand[addr_w-1:0];
              ret_st    <= sq_rd_data;
              state     <= sq_xlat;
            end
            op_exit: state <= sq_halt;
            default: state <= sq_fetch;  // register ops done by reg_op, unknown ops skipped
          endcase
        end
        sq_wr_data:  state <= sq_fetch;
        sq_rd_data:  state <= sq_get_data;
        sq_get_data: state <= sq_fetch;
        sq_halt:     state <= sq_halt;  // stays until reset
        default:     state <= sq_stop;
      endcase
    end
  end

endmodule

/* reg_alu.sv */
`timescale 1ns/1ps

module reg_alu import cpu_pkg::*; (
  input  logic                 clka,
  input  logic                 rst,
  input  reg_op_t              reg_op,
  input  logic [reg_idx_w-1:0] reg_sel,
  output logic [data_w-1:0]    reg_value
);

  logic [data_w-1:0] regs [reg_count];

  assign reg_value = regs[reg_sel];  // combinational read for the sequencer

  always_ff @(posedge clka) begin
    if (!rst) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else begin
      case (reg_op.kind)
        kind_load: regs[reg_op.idx] <= reg_op.value;
        kind_add:  regs[reg_op.idx] <= regs[reg_op.idx] + reg_op.value;  // wraps at 16 bits
        kind_sub:  regs[reg_op.idx] <= regs[reg_op.idx] - reg_op.value;
        default:   regs[reg_op.idx] <= regs[reg_op.idx];  // kind_none
      endcase
    end
  end

endmodule

/* page_mmu.sv */
`timescale 1ns/1ps

module page_mmu import cpu_pkg::*; (
  input  logic              clka,
  input  logic              rst,
  input  logic              xlat_req,
  input  logic [addr_w-1:0] xlat_addr,
  output logic              xlat_ack,
  output xlat_rsp_t         xlat_rsp
);

  logic [page_count-1:0] used;                  // physical page taken
  logic [page_idx_w-1:0] lpage   [page_count];  // logical page held by each physical page
  logic [page_idx_w-1:0] next_pg [page_count];  // chain link, tail points to itself

  logic [1:0]            state;
  logic [page_idx_w-1:0] last_lpage;  // last translation
  logic [page_idx_w-1:0] last_ppage;
  logic [page_idx_w-1:0] req_lpage;   // request being served
  logic [page_bits-1:0]  req_off;
  logic [page_idx_w-1:0] walk_ptr;
  logic [page_idx_w-1:0] tail;        // chain end, gets the new link
  logic [page_idx_w-1:0] alloc_ptr;   // free page search starts here
  logic [page_idx_w-1:0] scan_ptr;
  logic [page_idx_w-1:0] scan_cnt;    // pages checked so far

  assign xlat_ack = (state == mm_ack);

  always_ff @(posedge clka) begin
    if (!rst) begin
      state      <= mm_idle;
      used       <= '0;
      used[0]    <= 1'b1;  // logical 0 lives in physical 0
      for (int i = 0; i < page_count; i++) begin
        lpage[i]   <= '0;
        next_pg[i] <= '0;
      end
      last_lpage <= '0;
      last_ppage <= '0;
      alloc_ptr  <= page_idx_w'(1);
    end else begin
      case (state)
        mm_idle: if (xlat_req) begin
          req_lpage <= xlat_addr[addr_w-1:page_bits];
          req_off   <= xlat_addr[page_bits-1:0];
          if (xlat_addr[addr_w-1:page_bits] == last_lpage) begin  // cached page hit
            xlat_rsp.phys_addr <= {last_ppage, xlat_addr[page_bits-1:0]};
            xlat_rsp.fault     <= 1'b0;
            state              <= mm_ack;
          end else begin
            walk_ptr <= '0;  // chain starts at page 0
            state    <= mm_walk;
          end
        end
        mm_walk: begin
          if (lpage[walk_ptr] == req_lpage) begin
            xlat_rsp.phys_addr <= {walk_ptr, req_off};
            xlat_rsp.fault     <= 1'b0;
            last_lpage         <= req_lpage;
            last_ppage         <= walk_ptr;
            state              <= mm_ack;
          end else if (next_pg[walk_ptr] == walk_ptr) begin  // end of chain, allocate
            tail     <= walk_ptr;
            scan_ptr <= alloc_ptr;
            scan_cnt <= '0;
            state    <= mm_scan;
          end else begin
            walk_ptr <= next_pg[walk_ptr];
          end
        end
        mm_scan: begin
          if (!used[scan_ptr]) begin
            used[scan_ptr]     <= 1'b1;
            lpage[scan_ptr]    <= req_lpage;
            next_pg[scan_ptr]  <= scan_ptr;  // new tail
            next_pg[tail]      <= scan_ptr;
            alloc_ptr          <= scan_ptr + 1'b1;
            last_lpage         <= req_lpage;
            last_ppage         <= scan_ptr;
            xlat_rsp.phys_addr <= {scan_ptr, req_off};
            xlat_rsp.fault     <= 1'b0;
            state              <= mm_ack;
          end else if (scan_cnt == page_idx_w'(page_count - 1)) begin
            xlat_rsp.phys_addr <= '0;
            xlat_rsp.fault     <= 1'b1;  // memory full, nothing allocated
            state              <= mm_ack;
          end else begin
            scan_ptr <= scan_ptr + 1'b1;  // wraps over the page range
            scan_cnt <= scan_cnt + 1'b1;
          end
        end
        mm_ack: if (!xlat_req) state <= mm_idle;
        default: state <= mm_idle;
      endcase
    end
  end

endmodule

/* host_port.sv */
`timescale 1ns/1ps

module host_port import cpu_pkg::*; (
  input  logic              clka,
  input  logic              rst,
  input  logic              host_req,
  input  logic              host_we,
  input  logic [addr_w-1:0] host_addr,
  input  logic [data_w-1:0] host_wdata,
  output logic              host_ack,
  output logic [data_w-1:0] host_rdata,
  input  logic              core_idle,
  input  ram_wr_t           core_wr,
  input  ram_rd_t           core_rd,
  output ram_wr_t           ram_wr,
  output ram_rd_t           ram_rd,
  input  mem_word_u         ram_rdata
);

  logic [1:0] state;
  logic       start;  // new host access accepted this cycle

  assign start    = (state == hp_wait) && host_req && core_idle;  // held off while core runs
  assign host_ack = (state == hp_ack);

  always_comb begin
    if (core_idle) begin
      ram_wr.en   = start && host_we;
      ram_wr.addr = host_addr;
      ram_wr.data = host_wdata;
      ram_rd.en   = start && !host_we;
      ram_rd.addr = host_addr;
    end else begin
      ram_wr = core_wr;  // core owns ram while running
      ram_rd = core_rd;
    end
  end

  always_ff @(posedge clka) begin
    if (!rst) begin
      state <= hp_wait;
    end else begin
      case (state)
        hp_wait: if (start) state <= host_we ? hp_ack : hp_read;  // write done at once
        hp_read: state <= hp_ack;                                 // wait out read latency
        hp_ack:  if (!host_req) state <= hp_wait;                 // four-phase release
        default: state <= hp_wait;
      endcase
    end
  end

  always_ff @(posedge clka) begin
    if (state == hp_read) host_rdata <= ram_rdata.raw;  // valid while ack high
  end

endmodule

/* block_ram.sv */
`timescale 1ns/1ps

module block_ram import cpu_pkg::*; (
  input  logic      clka,
  input  ram_wr_t   wr,
  input  ram_rd_t   rd,
  output mem_word_u rdata
);

  logic [data_w-1:0] mem [page_count*page_words];  // 1024 words, all pages

  always_ff @(posedge clka) begin
    if (wr.en) begin
      mem[wr.addr] <= wr.data;
    end
    if (rd.en) begin
      rdata.raw <= mem[rd.addr];  // data one cycle after enable
    end
  end

endmodule

/* cpu_pkg.sv */
package cpu_pkg;

  // sizes
  localparam int addr_w     = 10;  // logical and physical word address
  localparam int data_w     = 16;  // ram word
  localparam int page_bits  = 6;   // offset bits inside a page
  localparam int page_words = 64;  // 2**page_bits
  localparam int page_count = 16;  // physical pages
  localparam int page_idx_w = 4;   // page number width
  localparam int reg_count  = 8;
  localparam int reg_idx_w  = 3;

  // opcodes, high byte of the head word
  localparam logic [7:0] op_jmp       = 8'd1;   // pc = operand
  localparam logic [7:0] op_ram2reg   = 8'd2;   // reg = ram[operand]
  localparam logic [7:0] op_reg2ram   = 8'd3;   // ram[operand] = reg
  localparam logic [7:0] op_num2reg   = 8'd4;   // reg = operand
  localparam logic [7:0] op_reg_plus  = 8'd5;   // reg += operand
  localparam logic [7:0] op_reg_minus = 8'd6;   // reg -= operand
  localparam logic [7:0] op_exit      = 8'd17;  // stop the core

  // register unit request kinds
  localparam logic [1:0] kind_none = 2'd0;
  localparam logic [1:0] kind_load = 2'd1;
  localparam logic [1:0] kind_add  = 2'd2;
  localparam logic [1:0] kind_sub  = 2'd3;

  // host port states
  localparam logic [1:0] hp_wait = 2'd0;  // waiting for a request while idle
  localparam logic [1:0] hp_read = 2'd1;  // ram read in flight
  localparam logic [1:0] hp_ack  = 2'd2;  // ack high until req drops

  // mmu states
  localparam logic [1:0] mm_idle = 2'd0;
  localparam logic [1:0] mm_walk = 2'd1;  // one chain entry per cycle
  localparam logic [1:0] mm_scan = 2'd2;  // search for a free page
  localparam logic [1:0] mm_ack  = 2'd3;

  // sequencer states
  localparam logic [3:0] sq_stop     = 4'd0;   // before run
  localparam logic [3:0] sq_fetch    = 4'd1;   // start translate of pc
  localparam logic [3:0] sq_xlat     = 4'd2;   // translate handshake, returns to ret_st
  localparam logic [3:0] sq_rd_head  = 4'd3;
  localparam logic [3:0] sq_get_head = 4'd4;
  localparam logic [3:0] sq_rd_arg   = 4'd5;
  localparam logic [3:0] sq_get_arg  = 4'd6;
  localparam logic [3:0] sq_exec     = 4'd7;
  localparam logic [3:0] sq_wr_data  = 4'd8;   // reg2ram write
  localparam logic [3:0] sq_rd_data  = 4'd9;   // ram2reg read
  localparam logic [3:0] sq_get_data = 4'd10;
  localparam logic [3:0] sq_halt     = 4'd11;

  typedef struct packed {
    logic [7:0] op;
    logic [7:0] reg_sel;
  } head_t;

  typedef union packed {
    head_t             head;  // first instruction word
    logic [data_w-1:0] raw;   // operand or data word
  } mem_word_u;

  typedef struct packed {
    logic              en;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
  } ram_wr_t;

  typedef struct packed {
    logic              en;
    logic [addr_w-1:0] addr;
  } ram_rd_t;

  typedef struct packed {
    logic [addr_w-1:0] phys_addr;
    logic              fault;  // no free page left
  } xlat_rsp_t;

  typedef struct packed {
    logic [1:0]           kind;  // kind_* above
    logic [reg_idx_w-1:0] idx;
    logic [data_w-1:0]    value;
  } reg_op_t;

endpackage
